// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module decodeStageTb -f sim.f -o simDecode
output=$(./obj_dir/simDecode 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== sim.f ====
+incdir+verilog
verilog/regPortIf.sv
verilog/decodePkg.sv
verilog/registerFile.sv
verilog/immediateGenerator.sv
verilog/instructionDecoder.sv
verilog/decodeRegister.sv
verilog/decodeStage.sv
sim/decodeStage_chk.sv
sim/decodeStageTb.sv

// ==== sim/decodeStageTb.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decodeStageTb;

    localparam int HALF_PERIOD = 2;
    localparam int CLOCK_PERIOD = 2 * HALF_PERIOD;
    localparam int WRITE_COUNT = 40;
    localparam int LEGAL_COUNT = 300;
    localparam int ILLEGAL_COUNT = 100;
    localparam int TEST_CYCLES = 8 + WRITE_COUNT + LEGAL_COUNT + ILLEGAL_COUNT + 40;

    logic                       clock;
    logic                       reset;
    logic                       instrValid;
    logic [`XLEN-1:0]           instruction;
    logic [`XLEN-1:0]           programCounter;
    logic                       writeEnable;
    logic [`REG_ADDR_WIDTH-1:0] writeAddress;
    logic [`XLEN-1:0]           writeData;
    logic                       stall;
    logic                       flush;
    decodePkg::decodedInstr_t   decoded;

    logic [`XLEN-1:0]         shadowRegs [`REG_COUNT];
    decodePkg::decodedInstr_t expected = '0;
    logic                     modelReady = 1'b0;

    logic [6:0] knownOpcodes [11] = '{
        decodePkg::OPCODE_ALU_REG, decodePkg::OPCODE_ALU_IMM, decodePkg::OPCODE_LOAD,
        decodePkg::OPCODE_STORE, decodePkg::OPCODE_BRANCH, decodePkg::OPCODE_LUI,
        decodePkg::OPCODE_AUIPC, decodePkg::OPCODE_JAL, decodePkg::OPCODE_JALR,
        decodePkg::OPCODE_MISC_MEM, decodePkg::OPCODE_SYSTEM
    };

    logic [31:0] illegalWords [10] = '{
        32'h0000_0073, 32'h3020_0073, 32'h0230_9113, 32'h0220_8033, 32'h0000_0000,
        32'hFFFF_FFFF, 32'h0000_3003, 32'h0000_4023, 32'h0000_2063, 32'h0000_2067
    };

    decodeStage u_decodeStage (
        .clock          (clock),
        .reset          (reset),
        .instrValid     (instrValid),
        .instruction    (instruction),
        .programCounter (programCounter),
        .writeEnable    (writeEnable),
        .writeAddress   (writeAddress),
        .writeData      (writeData),
        .stall          (stall),
        .flush          (flush),
        .decoded        (decoded)
    );

    always #HALF_PERIOD clock = ~clock;

    function automatic decodePkg::aluOp_t aluFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? decodePkg::ALU_SUB : decodePkg::ALU_ADD;
            3'd1: return decodePkg::ALU_SLL;
            3'd2: return decodePkg::ALU_SLT;
            3'd3: return decodePkg::ALU_SLTU;
            3'd4: return decodePkg::ALU_XOR;
            3'd5: return alt ? decodePkg::ALU_SRA : decodePkg::ALU_SRL;
            3'd6: return decodePkg::ALU_OR;
            default: return decodePkg::ALU_AND;
        endcase
    endfunction

    // Expected decode bundle with register data from the shadow copy
    function automatic decodePkg::decodedInstr_t refDecode(input logic valid,
                                                           input logic [31:0] instr,
                                                           input logic [31:0] pc);
        decodePkg::decodedInstr_t d;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] iImm;
        logic        useRs1;
        logic        useRs2;
        logic        useRd;
        d = '0;
        f3 = instr[14:12];
        f7 = instr[31:25];
        iImm = $signed(instr) >>> 20;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        useRd = 1'b0;
        d.valid = valid;
        d.programCounter = pc;
        d.programCounterPlus4 = pc + 32'd4;
        case (instr[6:0])
            decodePkg::OPCODE_ALU_REG: begin
                {useRs1, useRs2, useRd} = 3'b111;
                d.wbType = decodePkg::WB_ALU;
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
                    d.aluOp = aluFromFunct3(f3, f7[5]);
                else
                    d.illegal = 1'b1;
            end
            decodePkg::OPCODE_ALU_IMM: begin
                {useRs1, useRd} = 2'b11;
                d.aluSrc = decodePkg::ALU_RS1_IMM;
                d.wbType = decodePkg::WB_ALU;
                d.immediate = iImm;
                if (f3 != 3'd1 && f3 != 3'd5)
                    d.aluOp = aluFromFunct3(f3, 1'b0);
                else if (f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20))
                    d.aluOp = aluFromFunct3(f3, f7[5]);
                else
                    d.illegal = 1'b1; // Shift with a bad upper field
            end
            decodePkg::OPCODE_LOAD: begin
                {useRs1, useRd} = 2'b11;
                d.aluSrc = decodePkg::ALU_RS1_IMM;
                d.wbType = decodePkg::WB_MEM;
                d.memRead = 1'b1;
                d.memSigned = !f3[2];
                d.immediate = iImm;
                if (f3 == 3'd3 || f3 >= 3'd6)
                    d.illegal = 1'b1;
                else
                    d.memWidth = (f3[1:0] == 2'd2) ? decodePkg::MEM_WORD
                               : (f3[0] ? decodePkg::MEM_HALF : decodePkg::MEM_BYTE);
            end
            decodePkg::OPCODE_STORE: begin
                {useRs1, useRs2} = 2'b11;
                d.aluSrc = decodePkg::ALU_RS1_IMM;
                d.memWrite = 1'b1;
                d.immediate = {iImm[31:5], instr[11:7]};
                if (f3 > 3'd2)
                    d.illegal = 1'b1;
                else
                    d.memWidth = (f3 == 3'd2) ? decodePkg::MEM_WORD
                               : (f3[0] ? decodePkg::MEM_HALF : decodePkg::MEM_BYTE);
            end
            decodePkg::OPCODE_BRANCH: begin
                {useRs1, useRs2} = 2'b11;
                d.aluSrc = decodePkg::ALU_PC_IMM;
                d.immediate = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                case (f3)
                    3'd0: d.branchType = decodePkg::BR_EQ;
                    3'd1: d.branchType = decodePkg::BR_NE;
                    3'd4: d.branchType = decodePkg::BR_LT;
                    3'd5: d.branchType = decodePkg::BR_GE;
                    3'd6: d.branchType = decodePkg::BR_LTU;
                    3'd7: d.branchType = decodePkg::BR_GEU;
                    default: d.illegal = 1'b1;
                endcase
            end
            decodePkg::OPCODE_LUI, decodePkg::OPCODE_AUIPC: begin
                useRd = 1'b1;
                d.wbType = decodePkg::WB_ALU;
                d.immediate = instr & 32'hFFFF_F000;
                d.aluSrc = instr[5] ? decodePkg::ALU_ZERO_IMM : decodePkg::ALU_PC_IMM;
            end
            decodePkg::OPCODE_JAL: begin
                useRd = 1'b1;
                d.aluSrc = decodePkg::ALU_PC_IMM;
                d.wbType = decodePkg::WB_PC4;
                d.jumpType = decodePkg::JUMP_JAL;
                d.immediate = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            decodePkg::OPCODE_JALR: begin
                {useRs1, useRd} = 2'b11;
                d.aluSrc = decodePkg::ALU_RS1_IMM;
                d.wbType = decodePkg::WB_PC4;
                d.jumpType = decodePkg::JUMP_JALR;
                d.immediate = iImm;
                d.illegal = (f3 != 3'd0);
            end
            decodePkg::OPCODE_MISC_MEM: d.illegal = (f3 > 3'd1); // FENCE is a no-op
            default: d.illegal = 1'b1; // SYSTEM and unknown opcodes
        endcase
        d.rs1 = useRs1 ? instr[19:15] : 5'd0;
        d.rs2 = useRs2 ? instr[24:20] : 5'd0;
        d.rd = useRd ? instr[11:7] : 5'd0;
        d.regData1 = shadowRegs[d.rs1];
        d.regData2 = shadowRegs[d.rs2];
        return d;
    endfunction

    function automatic logic [31:0] randomLegal(input int kind);
        logic [31:0] w;
        logic [2:0]  f3;
        w = $urandom();
        f3 = w[14:12];
        case (kind)
            0: begin
                w[6:0] = decodePkg::OPCODE_ALU_REG;
                w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00;
            end
            1: begin
                w[6:0] = decodePkg::OPCODE_ALU_IMM;
                if (f3 == 3'd1)
                    w[31:25] = 7'h00;
                else if (f3 == 3'd5)
                    w[31:25] = w[30] ? 7'h20 : 7'h00;
            end
            2: begin
                w[6:0] = decodePkg::OPCODE_LOAD;
                if (f3 == 3'd3 || f3 >= 3'd6)
                    w[14:12] = 3'd2;
            end
            3: begin
                w[6:0] = decodePkg::OPCODE_STORE;
                w[14:12] = {1'b0, f3[1], f3[0] & ~f3[1]};
            end
            4: begin
                w[6:0] = decodePkg::OPCODE_BRANCH;
                if (f3 == 3'd2 || f3 == 3'd3)
                    w[14:12] = f3 + 3'd4;
            end
            5: w[6:0] = decodePkg::OPCODE_LUI;
            6: w[6:0] = decodePkg::OPCODE_AUIPC;
            7: w[6:0] = decodePkg::OPCODE_JAL;
            8: begin
                w[6:0] = decodePkg::OPCODE_JALR;
                w[14:12] = 3'd0;
            end
            default: begin
                w[6:0] = decodePkg::OPCODE_MISC_MEM;
                w[14:12] = 3'd0;
            end
        endcase
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expectedValue);
        if (actual !== expectedValue) begin
            $display("MISMATCH time=%0t %s actual=%h expected=%h",
                     $time, name, actual, expectedValue);
            $display("Test failed");
            $fatal(1, "decode output check failed");
        end
    endtask

    task automatic applyInstr(input logic [31:0] instr, input logic valid);
        logic [31:0] pcValue;
        pcValue = $urandom();
        instruction = instr;
        instrValid = valid;
        programCounter = pcValue & 32'hFFFF_FFFC;
    endtask

    task automatic driveCycle(input logic [31:0] instr, input logic valid);
        @(negedge clock);
        applyInstr(instr, valid);
    endtask

    // Stage register model stepped on each rising edge
    always @(posedge clock) begin
        decodePkg::decodedInstr_t fresh;
        fresh = refDecode(instrValid, instruction, programCounter);
        if (reset) begin
            expected = '0;
            for (int i = 0; i < `REG_COUNT; i++)
                shadowRegs[i] = '0;
            modelReady = 1'b1;
        end else begin
            if (flush)
                expected.valid = 1'b0;
            else if (!stall)
                expected = fresh;
            else begin
                expected.regData1 = fresh.regData1; // Writebacks seen while stalled
                expected.regData2 = fresh.regData2;
            end
            if (writeEnable && writeAddress != '0)
                shadowRegs[writeAddress] = writeData;
        end
    end

    always @(negedge clock) begin
        if (modelReady) begin
            checkValue("decoded.valid", 32'(decoded.valid), 32'(expected.valid));
            checkValue("decoded.illegal", 32'(decoded.illegal), 32'(expected.illegal));
            checkValue("decoded.programCounter", decoded.programCounter,
                       expected.programCounter);
            checkValue("decoded.programCounterPlus4", decoded.programCounterPlus4,
                       expected.programCounterPlus4);
            checkValue("decoded.rs1", 32'(decoded.rs1), 32'(expected.rs1));
            checkValue("decoded.rs2", 32'(decoded.rs2), 32'(expected.rs2));
            checkValue("decoded.rd", 32'(decoded.rd), 32'(expected.rd));
            checkValue("decoded.regData1", decoded.regData1, expected.regData1);
            checkValue("decoded.regData2", decoded.regData2, expected.regData2);
            checkValue("decoded.immediate", decoded.immediate, expected.immediate);
            checkValue("decoded.aluOp", 32'(decoded.aluOp), 32'(expected.aluOp));
            checkValue("decoded.aluSrc", 32'(decoded.aluSrc), 32'(expected.aluSrc));
            checkValue("decoded.wbType", 32'(decoded.wbType), 32'(expected.wbType));
            checkValue("decoded.branchType", 32'(decoded.branchType), 32'(expected.branchType));
            checkValue("decoded.jumpType", 32'(decoded.jumpType), 32'(expected.jumpType));
            checkValue("decoded.memRead", 32'(decoded.memRead), 32'(expected.memRead));
            checkValue("decoded.memWrite", 32'(decoded.memWrite), 32'(expected.memWrite));
            checkValue("decoded.memWidth", 32'(decoded.memWidth), 32'(expected.memWidth));
            checkValue("decoded.memSigned", 32'(decoded.memSigned), 32'(expected.memSigned));
        end
    end

    initial begin
        #((TEST_CYCLES + 50) * CLOCK_PERIOD);
        $display("Watchdog expired before the stimulus finished");
        $display("Test failed");
        $fatal(1, "simulation timeout");
    end

    initial begin
        logic [31:0] word;
        logic [31:0] stallValue;
        int          pick;
        void'($urandom(32'h69f8_fa3d));
        clock = 1'b0;
        reset = 1'b1;
        instrValid = 1'b0;
        instruction = '0;
        programCounter = '0;
        writeEnable = 1'b0;
        writeAddress = '0;
        writeData = '0;
        stall = 1'b0;
        flush = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        checkValue("decoded", 32'(decoded != '0), 32'd0);
        reset = 1'b0;

        for (int i = 0; i < WRITE_COUNT; i++) begin
            driveCycle(randomLegal(i % 4), 1'b1);
            writeEnable = 1'b1;
            writeAddress = (i % 8 == 0) ? '0 : `REG_ADDR_WIDTH'($urandom());
            writeData = $urandom();
        end
        // Write to x0 and read it back
        driveCycle({7'h00, 5'd0, 5'd0, 3'b000, 5'd1, 7'b0110011}, 1'b1);
        writeAddress = '0;
        writeData = 32'hDEAD_BEEF;
        @(negedge clock);
        writeEnable = 1'b0;
        @(negedge clock);
        checkValue("decoded.regData1", decoded.regData1, 32'd0);

        for (int i = 0; i < LEGAL_COUNT; i++)
            driveCycle(randomLegal(i % 10), (i % 7) != 0);

        for (int i = 0; i < 10; i++)
            driveCycle(illegalWords[i], 1'b1);
        for (int i = 0; i < ILLEGAL_COUNT; i++) begin
            word = $urandom();
            pick = int'($urandom() % 11);
            if (i % 2 == 1)
                word[6:0] = knownOpcodes[pick];
            driveCycle(word, 1'b1);
        end

        stallValue = $urandom();
        driveCycle({7'h00, 5'd6, 5'd5, 3'b000, 5'd3, 7'b0110011}, 1'b1);
        @(negedge clock);
        stall = 1'b1;
        // SUB x4 behind the stall, same sources as the held ADD
        applyInstr({7'h20, 5'd6, 5'd5, 3'b000, 5'd4, 7'b0110011}, 1'b1);
        @(negedge clock);
        writeEnable = 1'b1;
        writeAddress = 5'd5;
        writeData = stallValue;
        @(negedge clock);
        writeEnable = 1'b0;
        @(negedge clock);
        checkValue("decoded.regData1", decoded.regData1, stallValue);
        checkValue("decoded.rd", 32'(decoded.rd), 32'd3);
        stall = 1'b0;

        driveCycle(randomLegal(1), 1'b1);
        @(negedge clock);
        flush = 1'b1;
        @(negedge clock);
        checkValue("decoded.valid", 32'(decoded.valid), 32'd0);
        flush = 1'b0;
        applyInstr(randomLegal(2), 1'b1);
        @(negedge clock);
        checkValue("decoded.valid", 32'(decoded.valid), 32'd1);
        stall = 1'b1;
        flush = 1'b1;
        @(negedge clock);
        checkValue("decoded.valid", 32'(decoded.valid), 32'd0);
        stall = 1'b0;
        flush = 1'b0;
        applyInstr(randomLegal(7), 1'b1);
        @(negedge clock);
        checkValue("decoded.valid", 32'(decoded.valid), 32'd1);
        repeat (2) @(negedge clock);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== sim/decodeStage_chk.sv ====
`timescale 1ns/1ps

module decodeRegisterChecker (
    input logic                     clock,
    input logic                     reset,
    input logic                     stall,
    input logic                     flush,
    input decodePkg::decodedInstr_t decoded
);

    decodePkg::decodedInstr_t heldFields;

    always_comb begin
        heldFields = decoded;
        heldFields.regData1 = '0; // Refreshed during a stall
        heldFields.regData2 = '0;
    end

    flushClearsValid: assert property (@(posedge clock) disable iff (reset)
        flush |=> !decoded.valid)
        else $error("valid still set the cycle after a flush");

    stallHoldsFields: assert property (@(posedge clock) disable iff (reset)
        (stall && !flush) |=> (heldFields == $past(heldFields)))
        else $error("decoded fields changed while stalled");

    resetClearsValid: assert property (@(posedge clock) reset |=> !decoded.valid)
        else $error("valid set right after reset");

endmodule

bind decodeRegister decodeRegisterChecker u_decodeRegisterChecker (
    .clock   (clock),
    .reset   (reset),
    .stall   (stall),
    .flush   (flush),
    .decoded (decoded)
);

// ==== verilog/decodePkg.sv ====
`include "decode_settings.svh"

package decodePkg;

    typedef enum logic [6:0] {
        OPCODE_ALU_REG  = 7'b0110011,
        OPCODE_ALU_IMM  = 7'b0010011,
        OPCODE_LOAD     = 7'b0000011,
        OPCODE_STORE    = 7'b0100011,
        OPCODE_BRANCH   = 7'b1100011,
        OPCODE_LUI      = 7'b0110111,
        OPCODE_AUIPC    = 7'b0010111,
        OPCODE_JAL      = 7'b1101111,
        OPCODE_JALR     = 7'b1100111,
        OPCODE_MISC_MEM = 7'b0001111,
        OPCODE_SYSTEM   = 7'b1110011 // Not supported, decodes as illegal
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } aluOp_t;

    typedef enum logic [1:0] {
        ALU_RS1_RS2, ALU_RS1_IMM, ALU_PC_IMM, ALU_ZERO_IMM
    } aluSrc_t;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC4} wbType_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branchType_t;

    typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR} jumpType_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b11 // Execute stage decodes 2'b10 as reserved
    } memWidth_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE} immFormat_t;

    typedef struct packed {
        logic                       valid;
        logic                       illegal;
        logic [`XLEN-1:0]           programCounter;
        logic [`XLEN-1:0]           programCounterPlus4;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`XLEN-1:0]           regData1;
        logic [`XLEN-1:0]           regData2;
        logic [`XLEN-1:0]           immediate;
        aluOp_t                     aluOp;
        aluSrc_t                    aluSrc;
        wbType_t                    wbType;
        branchType_t                branchType;
        jumpType_t                  jumpType;
        logic                       memRead;
        logic                       memWrite;
        memWidth_t                  memWidth;
        logic                       memSigned;
    } decodedInstr_t;

endpackage

// ==== verilog/decodeRegister.sv ====
`timescale 1ns/1ps

module decodeRegister (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     flush,
    input  decodePkg::decodedInstr_t candidate,
    output decodePkg::decodedInstr_t decoded
);

    always_ff @(posedge clock) begin
        if (reset) begin
            decoded <= '0;
        end else if (flush) begin // Wins over stall
            decoded.valid <= 1'b0;
        end else if (!stall) begin
            decoded <= candidate;
        end else begin
            // Held instruction still picks up writebacks during the stall
            decoded.regData1 <= candidate.regData1;
            decoded.regData2 <= candidate.regData2;
        end
    end

endmodule

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decodeStage (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       instrValid,
    input  logic [`XLEN-1:0]           instruction,
    input  logic [`XLEN-1:0]           programCounter,
    input  logic                       writeEnable,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddress,
    input  logic [`XLEN-1:0]           writeData,
    input  logic                       stall,
    input  logic                       flush,
    output decodePkg::decodedInstr_t   decoded
);

    regPortIf regPort();

    decodePkg::immFormat_t    immFormat;
    logic [`XLEN-1:0]         immediate;
    decodePkg::decodedInstr_t candidate;

    registerFile u_registerFile (
        .clock        (clock),
        .reset        (reset),
        .writeEnable  (writeEnable),
        .writeAddress (writeAddress),
        .writeData    (writeData),
        .readPort     (regPort.server)
    );

    immediateGenerator u_immediateGenerator (
        .instruction (instruction),
        .immFormat   (immFormat),
        .immediate   (immediate)
    );

    instructionDecoder u_instructionDecoder (
        .instrValid     (instrValid),
        .instruction    (instruction),
        .programCounter (programCounter),
        .readPort       (regPort.client),
        .immFormat      (immFormat),
        .immediate      (immediate),
        .candidate      (candidate)
    );

    decodeRegister u_decodeRegister (
        .clock     (clock),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .candidate (candidate),
        .decoded   (decoded)
    );

endmodule

// ==== verilog/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath and address width
`define XLEN 32

// Integer register file geometry
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

`endif

// ==== verilog/immediateGenerator.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module immediateGenerator (
    input  logic [`XLEN-1:0]  instruction,
    input  decodePkg::immFormat_t immFormat,
    output logic [`XLEN-1:0]  immediate
);

    logic signBit;

    assign signBit = instruction[31];

    always_comb begin
        unique case (immFormat)
            decodePkg::IMM_I: begin
                immediate = {{(`XLEN-12){signBit}}, instruction[31:20]};
            end
            decodePkg::IMM_S: begin
                immediate = {{(`XLEN-12){signBit}}, instruction[31:25], instruction[11:7]};
            end
            decodePkg::IMM_B: begin // Halfword aligned offset
                immediate = {{(`XLEN-12){signBit}}, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            end
            decodePkg::IMM_U: begin
                immediate = {instruction[31:12], 12'd0};
            end
            decodePkg::IMM_J: begin
                immediate = {{(`XLEN-20){signBit}}, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            end
            default: begin
                immediate = '0; // IMM_NONE
            end
        endcase
    end

endmodule

// ==== verilog/instructionDecoder.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module instructionDecoder (
    input  logic                     instrValid,
    input  logic [`XLEN-1:0]         instruction,
    input  logic [`XLEN-1:0]         programCounter,
    regPortIf.client                 readPort,
    output decodePkg::immFormat_t    immFormat,
    input  logic [`XLEN-1:0]         immediate,
    output decodePkg::decodedInstr_t candidate
);

    decodePkg::opcode_t         opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [`REG_ADDR_WIDTH-1:0] rdField;
    logic [`REG_ADDR_WIDTH-1:0] rs1Field;
    logic [`REG_ADDR_WIDTH-1:0] rs2Field;

    assign opcode   = decodePkg::opcode_t'(instruction[6:0]);
    assign funct3   = instruction[14:12];
    assign funct7   = instruction[31:25];
    assign rdField  = instruction[11:7];
    assign rs1Field = instruction[19:15];
    assign rs2Field = instruction[24:20];

    always_comb begin
        candidate = '0;
        immFormat = decodePkg::IMM_NONE;
        readPort.readAddress1 = '0;
        readPort.readAddress2 = '0;
        candidate.valid = instrValid;
        candidate.programCounter = programCounter;
        candidate.programCounterPlus4 = programCounter + `XLEN'(4);
        unique case (opcode)
            decodePkg::OPCODE_ALU_REG: begin
                candidate.rd = rdField;
                readPort.readAddress1 = rs1Field;
                readPort.readAddress2 = rs2Field;
                candidate.aluSrc = decodePkg::ALU_RS1_RS2;
                candidate.wbType = decodePkg::WB_ALU;
                unique case ({funct7, funct3})
                    10'b0000000_000: candidate.aluOp = decodePkg::ALU_ADD;
                    10'b0100000_000: candidate.aluOp = decodePkg::ALU_SUB;
                    10'b0000000_001: candidate.aluOp = decodePkg::ALU_SLL;
                    10'b0000000_010: candidate.aluOp = decodePkg::ALU_SLT;
                    10'b0000000_011: candidate.aluOp = decodePkg::ALU_SLTU;
                    10'b0000000_100: candidate.aluOp = decodePkg::ALU_XOR;
                    10'b0000000_101: candidate.aluOp = decodePkg::ALU_SRL;
                    10'b0100000_101: candidate.aluOp = decodePkg::ALU_SRA;
                    10'b0000000_110: candidate.aluOp = decodePkg::ALU_OR;
                    10'b0000000_111: candidate.aluOp = decodePkg::ALU_AND;
                    default: candidate.illegal = 1'b1;
                endcase
            end
            decodePkg::OPCODE_ALU_IMM: begin
                candidate.rd = rdField;
                readPort.readAddress1 = rs1Field;
                candidate.aluSrc = decodePkg::ALU_RS1_IMM;
                candidate.wbType = decodePkg::WB_ALU;
                immFormat = decodePkg::IMM_I;
                unique case (funct3)
                    3'b000: candidate.aluOp = decodePkg::ALU_ADD;
                    3'b010: candidate.aluOp = decodePkg::ALU_SLT;
                    3'b011: candidate.aluOp = decodePkg::ALU_SLTU;
                    3'b100: candidate.aluOp = decodePkg::ALU_XOR;
                    3'b110: candidate.aluOp = decodePkg::ALU_OR;
                    3'b111: candidate.aluOp = decodePkg::ALU_AND;
                    3'b001: begin // Shift amount lives in rs2 field
                        if (funct7 == 7'b0000000)
                            candidate.aluOp = decodePkg::ALU_SLL;
                        else
                            candidate.illegal = 1'b1;
                    end
                    default: begin // 3'b101
                        if (funct7 == 7'b0000000)
                            candidate.aluOp = decodePkg::ALU_SRL;
                        else if (funct7 == 7'b0100000)
                            candidate.aluOp = decodePkg::ALU_SRA;
                        else
                            candidate.illegal = 1'b1;
                    end
                endcase
            end
            decodePkg::OPCODE_LOAD: begin
                candidate.rd = rdField;
                readPort.readAddress1 = rs1Field;
                candidate.aluSrc = decodePkg::ALU_RS1_IMM;
                candidate.wbType = decodePkg::WB_MEM;
                candidate.memRead = 1'b1;
                candidate.memSigned = ~funct3[2]; // LBU and LHU set bit 2
                immFormat = decodePkg::IMM_I;
                unique case (funct3)
                    3'b000, 3'b100: candidate.memWidth = decodePkg::MEM_BYTE;
                    3'b001, 3'b101: candidate.memWidth = decodePkg::MEM_HALF;
                    3'b010: candidate.memWidth = decodePkg::MEM_WORD;
                    default: candidate.illegal = 1'b1;
                endcase
            end
            decodePkg::OPCODE_STORE: begin
                readPort.readAddress1 = rs1Field;
                readPort.readAddress2 = rs2Field;
                candidate.aluSrc = decodePkg::ALU_RS1_IMM;
                candidate.memWrite = 1'b1;
                immFormat = decodePkg::IMM_S;
                unique case (funct3)
                    3'b000: candidate.memWidth = decodePkg::MEM_BYTE;
                    3'b001: candidate.memWidth = decodePkg::MEM_HALF;
                    3'b010: candidate.memWidth = decodePkg::MEM_WORD;
                    default: candidate.illegal = 1'b1;
                endcase
            end
            decodePkg::OPCODE_BRANCH: begin
                readPort.readAddress1 = rs1Field;
                readPort.readAddress2 = rs2Field;
                candidate.aluSrc = decodePkg::ALU_PC_IMM; // Target computed in ALU
                immFormat = decodePkg::IMM_B;
                unique case (funct3)
                    3'b000: candidate.branchType = decodePkg::BR_EQ;
                    3'b001: candidate.branchType = decodePkg::BR_NE;
                    3'b100: candidate.branchType = decodePkg::BR_LT;
                    3'b101: candidate.branchType = decodePkg::BR_GE;
                    3'b110: candidate.branchType = decodePkg::BR_LTU;
                    3'b111: candidate.branchType = decodePkg::BR_GEU;
                    default: candidate.illegal = 1'b1;
                endcase
            end
            decodePkg::OPCODE_LUI, decodePkg::OPCODE_AUIPC: begin
                candidate.rd = rdField;
                candidate.wbType = decodePkg::WB_ALU;
                immFormat = decodePkg::IMM_U;
                candidate.aluSrc = (opcode == decodePkg::OPCODE_LUI) ? decodePkg::ALU_ZERO_IMM
                                                                     : decodePkg::ALU_PC_IMM;
            end
            decodePkg::OPCODE_JAL: begin
                candidate.rd = rdField;
                candidate.aluSrc = decodePkg::ALU_PC_IMM;
                candidate.wbType = decodePkg::WB_PC4;
                candidate.jumpType = decodePkg::JUMP_JAL;
                immFormat = decodePkg::IMM_J;
            end
            decodePkg::OPCODE_JALR: begin
                candidate.rd = rdField;
                readPort.readAddress1 = rs1Field;
                candidate.aluSrc = decodePkg::ALU_RS1_IMM;
                candidate.wbType = decodePkg::WB_PC4;
                candidate.jumpType = decodePkg::JUMP_JALR;
                immFormat = decodePkg::IMM_I;
                candidate.illegal = (funct3 != 3'b000);
            end
            decodePkg::OPCODE_MISC_MEM: begin
                // FENCE and FENCE.I, in-order core so both are no-ops
                candidate.illegal = (funct3 != 3'b000) && (funct3 != 3'b001);
            end
            decodePkg::OPCODE_SYSTEM: candidate.illegal = 1'b1; // No CSR or trap support
            default: candidate.illegal = 1'b1;
        endcase
        candidate.rs1 = readPort.readAddress1; // Zero when the source is unused
        candidate.rs2 = readPort.readAddress2;
        candidate.regData1 = readPort.readData1;
        candidate.regData2 = readPort.readData2;
        candidate.immediate = immediate;
    end

endmodule

// ==== verilog/regPortIf.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

interface regPortIf;
    logic [`REG_ADDR_WIDTH-1:0] readAddress1;
    logic [`REG_ADDR_WIDTH-1:0] readAddress2;
    logic [`XLEN-1:0]           readData1;
    logic [`XLEN-1:0]           readData2;

    modport client (
        output readAddress1, readAddress2,
        input  readData1, readData2
    );

    modport server (
        input  readAddress1, readAddress2,
        output readData1, readData2
    );
endinterface

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module registerFile (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       writeEnable,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddress,
    input  logic [`XLEN-1:0]           writeData,
    regPortIf.server                   readPort
);

    logic [`XLEN-1:0] registers [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && writeAddress != '0) begin // x0 is hardwired
            registers[writeAddress] <= writeData;
        end
    end

    // No write-through, a write shows up from the next cycle
    always_comb begin
        readPort.readData1 = (readPort.readAddress1 == '0) ? '0
                           : registers[readPort.readAddress1];
        readPort.readData2 = (readPort.readAddress2 == '0) ? '0
                           : registers[readPort.readAddress2];
    end

endmodule
